// File: list.f
rtl/force_acc_pkg.sv
rtl/fp32_adder.sv
rtl/force_sample_stage.sv
rtl/force_accumulate_stage.sv
rtl/partial_force_acc.sv
dv/partial_force_acc_tb.sv

// File: Makefile
# Verilator build and run of the partial force accumulator testbench

VERILATOR ?= verilator
TOP ?= partial_force_acc_tb
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, and check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

# Output is kept in a shell variable and searched for the pass line
test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/partial_force_acc_tb.sv
// Directed testbench for the partial force accumulator, with reference model and watchdog
`timescale 1ns/10ps

module partial_force_acc_tb;
	import force_acc_pkg::*;

	localparam int ID_W = 20;
	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 4;
	localparam int PIPE_LATENCY = 2;
	localparam int DRAIN_LIMIT = 10;
	localparam int DIRECTED_TESTS = 5;
	localparam int DIRECTED_MAX = 24;
	localparam int RAND_PARTICLES = 16;
	localparam int RAND_MAX_LEN = 5;
	localparam int MARGIN = 50;
	localparam int TEST_TAIL = DRAIN_LIMIT + PIPE_LATENCY + 1;
	// Worst case stimulus cycles of all tests plus slack
	localparam int WATCHDOG_CYCLES = 2 * RESET_CYCLES + DIRECTED_TESTS * (DIRECTED_MAX + TEST_TAIL) +
		RAND_PARTICLES * RAND_MAX_LEN * 2 + 1 + TEST_TAIL + MARGIN;

	logic clk;
	logic rst;
	logic in_valid;
	logic flush;
	logic [ID_W-1:0] particle_id;
	logic [FORCE_WIDTH-1:0] force_x;
	logic [FORCE_WIDTH-1:0] force_y;
	logic [FORCE_WIDTH-1:0] force_z;
	logic acc_valid;
	logic [ID_W-1:0] acc_particle_id;
	logic [FORCE_WIDTH-1:0] acc_force_x;
	logic [FORCE_WIDTH-1:0] acc_force_y;
	logic [FORCE_WIDTH-1:0] acc_force_z;

	// Observed and expected beats
	logic [ID_W-1:0] got_id[$];
	logic [FORCE_WIDTH-1:0] got_x[$];
	logic [FORCE_WIDTH-1:0] got_y[$];
	logic [FORCE_WIDTH-1:0] got_z[$];
	logic [ID_W-1:0] exp_id[$];
	logic [FORCE_WIDTH-1:0] exp_x[$];
	logic [FORCE_WIDTH-1:0] exp_y[$];
	logic [FORCE_WIDTH-1:0] exp_z[$];

	// Reference model, sums counted in halves
	logic [ID_W-1:0] mdl_cur_id;
	logic [ID_W-1:0] mdl_last_id;
	bit mdl_known;
	bit mdl_holding;
	int mdl_sx;
	int mdl_sy;
	int mdl_sz;

	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	int test_start_errors;
	logic [31:0] rng_state;

	partial_force_acc #(.PARTICLE_ID_WIDTH(ID_W)) dut_i
	(
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.flush(flush),
		.particle_id(particle_id),
		.force_x(force_x),
		.force_y(force_y),
		.force_z(force_z),
		.acc_valid(acc_valid),
		.acc_particle_id(acc_particle_id),
		.acc_force_x(acc_force_x),
		.acc_force_y(acc_force_y),
		.acc_force_z(acc_force_z)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Outputs sampled mid-cycle, away from the edge
	always @(negedge clk)
	begin
		if (!rst && acc_valid)
		begin
			got_id.push_back(acc_particle_id);
			got_x.push_back(acc_force_x);
			got_y.push_back(acc_force_y);
			got_z.push_back(acc_force_z);
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Float from a count of halves, exact for small values
	function automatic logic [31:0] half_to_float(input int halves);
		logic sign;
		int mag;
		int msb;
		logic [31:0] man;
		if (halves == 0)
			return 32'h0;
		sign = (halves < 0);
		mag = sign ? -halves : halves;
		msb = 0;
		for (int i = 0; i < 31; i++)
			if (mag[i])
				msb = i;
		man = 32'(mag) << (23 - msb);
		return {sign, 8'(126 + msb), man[22:0]};
	endfunction

	function logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state >> 8;
	endfunction

	function int rand_below(input int n);
		return int'(lcg_next() % 32'(n));
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		checks++;
		if (got !== expected)
		begin
			$display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
			errors++;
		end
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic push_expected();
		exp_id.push_back(mdl_cur_id);
		exp_x.push_back(half_to_float(mdl_sx));
		exp_y.push_back(half_to_float(mdl_sy));
		exp_z.push_back(half_to_float(mdl_sz));
	endtask

	// One input cycle, model follows the classification rules
	task automatic send(input bit valid, input logic [ID_W-1:0] id, input int hx, input int hy,
		input int hz);
		in_valid = valid;
		particle_id = id;
		force_x = half_to_float(hx);
		force_y = half_to_float(hy);
		force_z = half_to_float(hz);
		if (valid)
		begin
			if (mdl_known && id == mdl_last_id)
			begin
				mdl_sx += hx;
				mdl_sy += hy;
				mdl_sz += hz;
			end
			else
			begin
				// Boundary, held particle leaves
				if (mdl_holding)
					push_expected();
				mdl_cur_id = id;
				mdl_sx = hx;
				mdl_sy = hy;
				mdl_sz = hz;
				mdl_holding = 1'b1;
			end
			mdl_last_id = id;
			mdl_known = 1'b1;
		end
		step();
		in_valid = 1'b0;
	endtask

	// Invalid cycle, ID and forces are junk
	task automatic gap(input logic [ID_W-1:0] id);
		send(1'b0, id, 99, -99, 99);
	endtask

	task automatic send_flush();
		flush = 1'b1;
		if (mdl_holding)
			push_expected();
		mdl_holding = 1'b0;
		mdl_known = 1'b0;
		step();
		flush = 1'b0;
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		in_valid = 1'b0;
		flush = 1'b0;
		mdl_holding = 1'b0;
		mdl_known = 1'b0;
		repeat (RESET_CYCLES) step();
		rst = 1'b0;
	endtask

	task automatic start_test();
		test_start_errors = errors;
	endtask

	// Wait for the expected beats, then compare in order
	task automatic drain_and_check(input string name);
		int waited;
		int n;
		waited = 0;
		while (got_id.size() < exp_id.size() && waited < DRAIN_LIMIT)
		begin
			step();
			waited++;
		end
		if (got_id.size() < exp_id.size())
		begin
			$display("Timed out in %s waiting for output beats from the DUT", name);
			errors++;
		end
		// Fixed latency window catches any extra beat
		repeat (PIPE_LATENCY + 1) step();
		check_value(got_id.size(), exp_id.size(), {name, " beat count"});
		n = (got_id.size() < exp_id.size()) ? got_id.size() : exp_id.size();
		for (int i = 0; i < n; i++)
		begin
			check_value(32'(got_id[i]), 32'(exp_id[i]), $sformatf("%s beat %0d id", name, i));
			check_value(got_x[i], exp_x[i], $sformatf("%s beat %0d x", name, i));
			check_value(got_y[i], exp_y[i], $sformatf("%s beat %0d y", name, i));
			check_value(got_z[i], exp_z[i], $sformatf("%s beat %0d z", name, i));
		end
		tests_run++;
		if (errors == test_start_errors)
			$display("Test %s passed", name);
		else
		begin
			tests_failed++;
			$display("Test %s failed", name);
		end
		got_id.delete();
		got_x.delete();
		got_y.delete();
		got_z.delete();
		exp_id.delete();
		exp_x.delete();
		exp_y.delete();
		exp_z.delete();
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	// Six samples of 2.0 with gaps, then a second particle and two flushes
	task automatic test_gap_run();
		start_test();
		for (int i = 0; i < 6; i++)
		begin
			send(1'b1, 20'd5, 4, 2, -2);
			if (i % 2 == 0)
				gap(20'd5);
		end
		send(1'b1, 20'd6, 1, 1, 1);
		send_flush();
		send_flush();
		drain_and_check("gap_run");
	endtask

	// New ID on invalid cycles must not end or start a particle
	task automatic test_invalid_id();
		start_test();
		send(1'b1, 20'd1, 2, 2, 2);
		gap(20'd3);
		send(1'b1, 20'd1, 2, 0, -4);
		gap(20'd3);
		gap(20'd3);
		send(1'b1, 20'd2, 6, 8, 10);
		gap(20'd3);
		send_flush();
		drain_and_check("invalid_id");
	endtask

	// Per-axis sums with negatives, x and z cancel to +0
	task automatic test_axes();
		start_test();
		send(1'b1, 20'd10, 2, -4, 6);
		send(1'b1, 20'd10, 8, 10, -6);
		send(1'b1, 20'd10, -10, 12, 0);
		send(1'b1, 20'd11, -3, 1, -15);
		send_flush();
		drain_and_check("axes");
	endtask

	// Single-sample particles every cycle, two in flight
	task automatic test_back_to_back();
		start_test();
		for (int i = 0; i < 8; i++)
			send(1'b1, ID_W'(20 + i), i + 1, -(i + 1), 2 * i);
		send_flush();
		drain_and_check("back_to_back");
	endtask

	task automatic test_random();
		logic [ID_W-1:0] id;
		int len;
		start_test();
		for (int p = 0; p < RAND_PARTICLES; p++)
		begin
			id = ID_W'(rand_below(64));
			len = 1 + rand_below(RAND_MAX_LEN);
			for (int s = 0; s < len; s++)
			begin
				if (rand_below(4) == 0)
					gap(ID_W'(rand_below(64)));
				send(1'b1, id, rand_below(201) - 100, rand_below(201) - 100,
					rand_below(201) - 100);
			end
		end
		send_flush();
		drain_and_check("random");
	endtask

	// Reset mid-particle, same ID afterwards is a fresh start
	task automatic test_reset_discard();
		start_test();
		send(1'b1, 20'd7, 2, 2, 2);
		send(1'b1, 20'd7, 2, 2, 2);
		apply_reset();
		send(1'b1, 20'd7, 6, 4, 2);
		send(1'b1, 20'd7, 2, 2, 2);
		send_flush();
		drain_and_check("reset_discard");
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		rst = 1'b1;
		in_valid = 1'b0;
		flush = 1'b0;
		particle_id = '0;
		force_x = '0;
		force_y = '0;
		force_z = '0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		rng_state = 32'h42bf36fb;
		mdl_cur_id = '0;
		mdl_last_id = '0;
		mdl_sx = 0;
		mdl_sy = 0;
		mdl_sz = 0;
		apply_reset();
		test_gap_run();
		test_invalid_id();
		test_axes();
		test_back_to_back();
		test_random();
		test_reset_discard();
		$display("Tests run %0d, tests failed %0d, checks %0d, mismatches %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: rtl/partial_force_acc.sv
// Per-particle partial force accumulator, sample stage followed by accumulate stage
`timescale 1ns/10ps

module partial_force_acc
#(
	parameter int PARTICLE_ID_WIDTH = 20
)
(
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	input  logic flush,
	input  logic [PARTICLE_ID_WIDTH-1:0] particle_id,
	input  logic [force_acc_pkg::FORCE_WIDTH-1:0] force_x,
	input  logic [force_acc_pkg::FORCE_WIDTH-1:0] force_y,
	input  logic [force_acc_pkg::FORCE_WIDTH-1:0] force_z,
	output logic acc_valid,
	output logic [PARTICLE_ID_WIDTH-1:0] acc_particle_id,
	output logic [force_acc_pkg::FORCE_WIDTH-1:0] acc_force_x,
	output logic [force_acc_pkg::FORCE_WIDTH-1:0] acc_force_y,
	output logic [force_acc_pkg::FORCE_WIDTH-1:0] acc_force_z
);
	import force_acc_pkg::*;

	// Registered, classified sample
	sample_op_t s_op;
	logic [PARTICLE_ID_WIDTH-1:0] s_particle_id;
	logic [FORCE_WIDTH-1:0] s_force_x;
	logic [FORCE_WIDTH-1:0] s_force_y;
	logic [FORCE_WIDTH-1:0] s_force_z;

	////////////////////////////////////////////////////////////
	// Stage one, register and classify
	////////////////////////////////////////////////////////////

	force_sample_stage
	#(
		.PARTICLE_ID_WIDTH(PARTICLE_ID_WIDTH)
	)
	u_sample
	(
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.flush(flush),
		.particle_id(particle_id),
		.force_x(force_x),
		.force_y(force_y),
		.force_z(force_z),
		.s_op(s_op),
		.s_particle_id(s_particle_id),
		.s_force_x(s_force_x),
		.s_force_y(s_force_y),
		.s_force_z(s_force_z)
	);

	////////////////////////////////////////////////////////////
	// Stage two, sum and emit
	////////////////////////////////////////////////////////////

	force_accumulate_stage
	#(
		.PARTICLE_ID_WIDTH(PARTICLE_ID_WIDTH)
	)
	u_accumulate
	(
		.clk(clk),
		.rst(rst),
		.s_op(s_op),
		.s_particle_id(s_particle_id),
		.s_force_x(s_force_x),
		.s_force_y(s_force_y),
		.s_force_z(s_force_z),
		.acc_valid(acc_valid),
		.acc_particle_id(acc_particle_id),
		.acc_force_x(acc_force_x),
		.acc_force_y(acc_force_y),
		.acc_force_z(acc_force_z)
	);

endmodule

// File: rtl/force_accumulate_stage.sv
// Accumulate stage, keeps running x/y/z sums per particle and emits finished particles
`timescale 1ns/10ps

module force_accumulate_stage
#(
	parameter int PARTICLE_ID_WIDTH = 20
)
(
	input  logic clk,
	input  logic rst,
	input  force_acc_pkg::sample_op_t s_op,
	input  logic [PARTICLE_ID_WIDTH-1:0] s_particle_id,
	input  logic [force_acc_pkg::FORCE_WIDTH-1:0] s_force_x,
	input  logic [force_acc_pkg::FORCE_WIDTH-1:0] s_force_y,
	input  logic [force_acc_pkg::FORCE_WIDTH-1:0] s_force_z,
	output logic acc_valid,
	output logic [PARTICLE_ID_WIDTH-1:0] acc_particle_id,
	output logic [force_acc_pkg::FORCE_WIDTH-1:0] acc_force_x,
	output logic [force_acc_pkg::FORCE_WIDTH-1:0] acc_force_y,
	output logic [force_acc_pkg::FORCE_WIDTH-1:0] acc_force_z
);
	import force_acc_pkg::*;

	acc_state_t state;

	// Particle currently being summed
	logic [PARTICLE_ID_WIDTH-1:0] cur_id;
	logic [FORCE_WIDTH-1:0] sum_x;
	logic [FORCE_WIDTH-1:0] sum_y;
	logic [FORCE_WIDTH-1:0] sum_z;

	// Adder results, sum plus incoming component
	logic [FORCE_WIDTH-1:0] add_x;
	logic [FORCE_WIDTH-1:0] add_y;
	logic [FORCE_WIDTH-1:0] add_z;

	// Held particle leaves on a boundary op
	logic emit;

	assign emit = ((s_op == OP_START) || (s_op == OP_FLUSH)) && (state == ACC_HOLDING);

	////////////////////////////////////////////////////////////
	// One adder per axis
	////////////////////////////////////////////////////////////

	fp32_adder u_add_x
	(
		.a(sum_x),
		.b(s_force_x),
		.sum(add_x)
	);

	fp32_adder u_add_y
	(
		.a(sum_y),
		.b(s_force_y),
		.sum(add_y)
	);

	fp32_adder u_add_z
	(
		.a(sum_z),
		.b(s_force_z),
		.sum(add_z)
	);

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ACC_EMPTY;
			acc_valid <= 1'b0;
		end
		else
		begin
			acc_valid <= emit;	// Single-cycle pulse per emission
			if (s_op == OP_START)
				state <= ACC_HOLDING;
			else if (s_op == OP_FLUSH)
				state <= ACC_EMPTY;
		end
	end

	////////////////////////////////////////////////////////////
	// Sums and output registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		// Snapshot before the new particle overwrites the sums
		if (emit)
		begin
			acc_particle_id <= cur_id;
			acc_force_x <= sum_x;
			acc_force_y <= sum_y;
			acc_force_z <= sum_z;
		end
		case (s_op)
			OP_START:
			begin
				cur_id <= s_particle_id;
				sum_x <= s_force_x;
				sum_y <= s_force_y;
				sum_z <= s_force_z;
			end
			OP_ADD:
			begin
				sum_x <= add_x;
				sum_y <= add_y;
				sum_z <= add_z;
			end
			default:
			begin
				// Idle and flush leave sums alone
			end
		endcase
	end

	// Sample stage never sends an add without a start first
	a_no_add_when_empty: assert property (@(posedge clk) disable iff (rst)
		(s_op == OP_ADD) |-> (state == ACC_HOLDING));

	// Pulse drops unless another boundary follows at once
	a_valid_one_cycle: assert property (@(posedge clk) disable iff (rst)
		(acc_valid && !(s_op inside {OP_START, OP_FLUSH})) |=> !acc_valid);

endmodule

// File: rtl/force_sample_stage.sv
// Sample stage, registers each force sample and classifies it against the last particle ID
`timescale 1ns/10ps

module force_sample_stage
#(
	parameter int PARTICLE_ID_WIDTH = 20
)
(
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	input  logic flush,
	input  logic [PARTICLE_ID_WIDTH-1:0] particle_id,
	input  logic [force_acc_pkg::FORCE_WIDTH-1:0] force_x,
	input  logic [force_acc_pkg::FORCE_WIDTH-1:0] force_y,
	input  logic [force_acc_pkg::FORCE_WIDTH-1:0] force_z,
	output force_acc_pkg::sample_op_t s_op,
	output logic [PARTICLE_ID_WIDTH-1:0] s_particle_id,
	output logic [force_acc_pkg::FORCE_WIDTH-1:0] s_force_x,
	output logic [force_acc_pkg::FORCE_WIDTH-1:0] s_force_y,
	output logic [force_acc_pkg::FORCE_WIDTH-1:0] s_force_z
);
	import force_acc_pkg::*;

	// Last valid ID and whether it is meaningful
	logic [PARTICLE_ID_WIDTH-1:0] last_id;
	logic id_known;
	sample_op_t next_op;

	// Classification, the only ID compare in the design
	always_comb
	begin
		if (flush)
			next_op = OP_FLUSH;
		else if (!in_valid)
			next_op = OP_IDLE;	// Gap cycle, ID ignored
		else if (id_known && (particle_id == last_id))
			next_op = OP_ADD;
		else
			next_op = OP_START;
	end

	// Control state
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			s_op <= OP_IDLE;
			id_known <= 1'b0;
		end
		else
		begin
			s_op <= next_op;
			if (flush)
				id_known <= 1'b0;	// Next valid sample starts fresh
			else if (in_valid)
				id_known <= 1'b1;
		end
	end

	// Payload, meaningful only alongside s_op
	always_ff @(posedge clk)
	begin
		if (in_valid && !flush)
			last_id <= particle_id;
		s_particle_id <= particle_id;
		s_force_x <= force_x;
		s_force_y <= force_y;
		s_force_z <= force_z;
	end

	// Upstream contract, flush only between runs
	a_flush_not_valid: assert property (@(posedge clk) disable iff (rst)
		!(flush && in_valid));

endmodule

// File: rtl/fp32_adder.sv
// Combinational single-precision adder with round to nearest even, denormal flush and saturation
`timescale 1ns/10ps

module fp32_adder
(
	input  logic [force_acc_pkg::FORCE_WIDTH-1:0] a,
	input  logic [force_acc_pkg::FORCE_WIDTH-1:0] b,
	output logic [force_acc_pkg::FORCE_WIDTH-1:0] sum
);
	import force_acc_pkg::*;

	// Hidden bit, mantissa, guard, round, sticky
	localparam int EXT_WIDTH = FP_MAN_WIDTH + 4;
	localparam int SIGN_BIT = FORCE_WIDTH - 1;

	// Unbiased exponent limits of the normal range
	localparam logic signed [9:0] EXP_HI = 10'(FP_EXP_BIAS);
	localparam logic signed [9:0] EXP_LO = 10'(1 - FP_EXP_BIAS);

	// Leading zero count of the raw magnitude
	// All zero gives the full width
	function automatic logic [4:0] lead_zeros(input logic [EXT_WIDTH:0] v);
		logic [4:0] cnt;
		logic found;
		cnt = 5'(EXT_WIDTH + 1);
		found = 1'b0;
		for (int i = EXT_WIDTH; i >= 0; i--)
		begin
			if (!found && v[i])
			begin
				cnt = 5'(EXT_WIDTH - i);
				found = 1'b1;
			end
		end
		return cnt;
	endfunction

	logic a_zero;
	logic b_zero;
	logic [EXT_WIDTH-1:0] a_ext;
	logic [EXT_WIDTH-1:0] b_ext;
	logic a_larger;
	logic big_sign;
	logic small_sign;
	logic [FP_EXP_WIDTH-1:0] big_exp;
	logic [FP_EXP_WIDTH-1:0] small_exp;
	logic [EXT_WIDTH-1:0] big_ext;
	logic [EXT_WIDTH-1:0] small_ext;
	logic [FP_EXP_WIDTH-1:0] exp_diff;
	logic [4:0] shamt;
	logic [2*EXT_WIDTH-1:0] shift_wide;
	logic [EXT_WIDTH-1:0] small_aligned;
	logic [EXT_WIDTH:0] mag_sum;
	logic [4:0] lz;
	logic [EXT_WIDTH:0] norm;
	logic guard_bit;
	logic sticky_bit;
	logic round_up;
	logic [FP_MAN_WIDTH+1:0] man_round;
	logic [FP_MAN_WIDTH-1:0] man_field;
	logic signed [9:0] exp_unb;
	logic [FP_EXP_WIDTH-1:0] exp_field;

	////////////////////////////////////////////////////////////
	// Unpack and order by magnitude
	////////////////////////////////////////////////////////////

	// Zero and denormal both count as zero
	assign a_zero = (a[FP_MAN_WIDTH +: FP_EXP_WIDTH] == '0);
	assign b_zero = (b[FP_MAN_WIDTH +: FP_EXP_WIDTH] == '0);

	assign a_ext = a_zero ? '0 : {1'b1, a[FP_MAN_WIDTH-1:0], 3'b000};
	assign b_ext = b_zero ? '0 : {1'b1, b[FP_MAN_WIDTH-1:0], 3'b000};

	// Exponent and mantissa compare as one unsigned field
	assign a_larger = (a[SIGN_BIT-1:0] >= b[SIGN_BIT-1:0]);

	assign big_sign   = a_larger ? a[SIGN_BIT] : b[SIGN_BIT];
	assign small_sign = a_larger ? b[SIGN_BIT] : a[SIGN_BIT];
	assign big_exp    = a_larger ? a[FP_MAN_WIDTH +: FP_EXP_WIDTH] :
		b[FP_MAN_WIDTH +: FP_EXP_WIDTH];
	assign small_exp  = a_larger ? b[FP_MAN_WIDTH +: FP_EXP_WIDTH] :
		a[FP_MAN_WIDTH +: FP_EXP_WIDTH];
	assign big_ext    = a_larger ? a_ext : b_ext;
	assign small_ext  = a_larger ? b_ext : a_ext;

	////////////////////////////////////////////////////////////
	// Align the smaller operand
	////////////////////////////////////////////////////////////

	assign exp_diff = big_exp - small_exp;

	// Past the extended width everything lands in sticky
	assign shamt = (exp_diff > FP_EXP_WIDTH'(EXT_WIDTH)) ? 5'(EXT_WIDTH) : exp_diff[4:0];

	assign shift_wide = {small_ext, {EXT_WIDTH{1'b0}}} >> shamt;

	// Shifted-out bits fold into the sticky position
	assign small_aligned = {shift_wide[2*EXT_WIDTH-1:EXT_WIDTH+1],
		shift_wide[EXT_WIDTH] | (|shift_wide[EXT_WIDTH-1:0])};

	// Effective add or subtract
	// Big magnitude is never below small
	assign mag_sum = (big_sign == small_sign) ?
		({1'b0, big_ext} + {1'b0, small_aligned}) :
		({1'b0, big_ext} - {1'b0, small_aligned});

	////////////////////////////////////////////////////////////
	// Normalise and round
	////////////////////////////////////////////////////////////

	assign lz   = lead_zeros(mag_sum);
	assign norm = mag_sum << lz;

	// Hidden bit on top followed by mantissa, guard and sticky
	assign guard_bit  = norm[3];
	assign sticky_bit = |norm[2:0];
	assign round_up   = guard_bit & (sticky_bit | norm[4]);

	assign man_round = {1'b0, norm[EXT_WIDTH:4]} + (FP_MAN_WIDTH+2)'(round_up);

	// A rounding carry leaves the low mantissa bits all zero
	assign man_field = man_round[FP_MAN_WIDTH-1:0];

	// Top of the 28-bit sum sits one above the big operand's weight
	assign exp_unb = 10'(big_exp) - 10'(FP_EXP_BIAS) + 10'd1 - 10'(lz) +
		10'(man_round[FP_MAN_WIDTH+1]);

	assign exp_field = FP_EXP_WIDTH'(exp_unb + 10'(FP_EXP_BIAS));

	////////////////////////////////////////////////////////////
	// Repack
	////////////////////////////////////////////////////////////

	always_comb
	begin
		if (mag_sum == '0)
			sum = '0;	// Exact cancellation or zero operands give +0
		else if (exp_unb > EXP_HI)
			sum = {big_sign, FP_EXP_MAX, {FP_MAN_WIDTH{1'b0}}};
		else if (exp_unb < EXP_LO)
			sum = {big_sign, {(FORCE_WIDTH-1){1'b0}}};	// Below normal range
		else
			sum = {big_sign, exp_field, man_field};
	end

endmodule

// File: rtl/force_acc_pkg.sv
// Force accumulator package with float field constants and shared enums
package force_acc_pkg;

	////////////////////////////////////////////////////////////
	// IEEE-754 single precision layout
	////////////////////////////////////////////////////////////

	// One force component
	localparam int FORCE_WIDTH = 32;

	// Field widths, hidden bit not stored
	localparam int FP_EXP_WIDTH = 8;
	localparam int FP_MAN_WIDTH = 23;

	// Exponent bias, also the largest unbiased normal exponent
	localparam int FP_EXP_BIAS = 127;

	// All-ones exponent, used for saturated infinity
	localparam logic [FP_EXP_WIDTH-1:0] FP_EXP_MAX = '1;

	////////////////////////////////////////////////////////////
	// Pipeline encodings
	////////////////////////////////////////////////////////////

	// Class of a registered sample, sample stage to accumulate stage
	typedef enum logic [1:0]
	{
		OP_IDLE  = 2'd0,	// Nothing to do
		OP_ADD   = 2'd1,	// Same particle, add to sums
		OP_START = 2'd2,	// New particle, emit old and load
		OP_FLUSH = 2'd3		// End of stream, emit old
	} sample_op_t;

	// Accumulator occupancy
	typedef enum logic
	{
		ACC_EMPTY   = 1'b0,
		ACC_HOLDING = 1'b1
	} acc_state_t;

endpackage
